//--- common/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// datapath widths
`define CPU_WORD_W       32
`define CPU_REG_CNT      32
`define CPU_REG_IDX_W    5
`define CPU_IMM_W        16
`define CPU_SHAMT_W      5
`define CPU_OPCODE_W     6
`define CPU_FN_W         6
`define CPU_ALU_OP_W     4          // alu function comes from the low opcode bits

// register operations carry a rotate amount and this function field
`define CPU_FN_IMM_SHIFT 6'b000000

`define CPU_OP_AND       6'b000000
`define CPU_OP_OR        6'b000001
`define CPU_OP_NOR       6'b000010
`define CPU_OP_XOR       6'b000011
`define CPU_OP_ADD       6'b000100
`define CPU_OP_SUB       6'b000101
`define CPU_OP_ANDI      6'b100000
`define CPU_OP_ORI       6'b100001
`define CPU_OP_XORI      6'b100011
`define CPU_OP_ADDI      6'b100100
`define CPU_OP_LW        6'b101000
`define CPU_OP_SW        6'b101001
`define CPU_OP_BEQ       6'b010101  // low bits select sub for the compare
`define CPU_OP_BNE       6'b110101
`define CPU_OP_NOP       6'b010011
`define CPU_OP_HALT      6'b010111

`endif

//--- common/cpu_pkg.sv
`include "cpu_macros.svh"

package cpu_pkg;

    typedef logic [`CPU_WORD_W-1:0]    word_t;     // bus, register, pc or memory word
    typedef logic [`CPU_REG_IDX_W-1:0] reg_idx_t;
    typedef logic [`CPU_IMM_W-1:0]     imm_t;      // raw immediate, sign extended on the bus
    typedef logic [`CPU_SHAMT_W-1:0]   shamt_t;    // left rotate amount
    typedef logic [`CPU_FN_W-1:0]      fn_t;
    typedef logic [`CPU_ALU_OP_W-1:0]  alu_op_t;

    typedef enum logic [`CPU_OPCODE_W-1:0] {
        op_and  = `CPU_OP_AND,
        op_or   = `CPU_OP_OR,
        op_nor  = `CPU_OP_NOR,
        op_xor  = `CPU_OP_XOR,
        op_add  = `CPU_OP_ADD,
        op_sub  = `CPU_OP_SUB,
        op_andi = `CPU_OP_ANDI,
        op_ori  = `CPU_OP_ORI,
        op_xori = `CPU_OP_XORI,
        op_addi = `CPU_OP_ADDI,
        op_lw   = `CPU_OP_LW,
        op_sw   = `CPU_OP_SW,
        op_beq  = `CPU_OP_BEQ,
        op_bne  = `CPU_OP_BNE,
        op_nop  = `CPU_OP_NOP,
        op_halt = `CPU_OP_HALT
    } opcode_e;

    typedef enum logic [2:0] {
        bus_pc,
        bus_reg,
        bus_imm,
        bus_alu,
        bus_membuf
    } bus_src_e;

    typedef enum logic [4:0] {
        fetch_addr, fetch_wait, decode,
        alu_op, alu_wb, imm_op, imm_wb,
        br_cmp, br_test, br_add, br_load,
        mem_addr, mem_mar, load_wait, load_wb, store_wait,
        done, fault
    } state_e;

endpackage

//--- control/cpu_control.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_control import cpu_pkg::*; (
    input  logic     clk,
    input  logic     reset_b,
    input  word_t    instr,
    input  logic     mem_ready,
    input  logic     alu_zero,
    input  logic     alu_ovf,
    output bus_src_e bus_src,
    output reg_idx_t rd_idx,
    output logic     reg_wr,
    output logic     ir_load,
    output logic     mar_load,
    output logic     mdr_load,
    output logic     alu_a_load,
    output logic     alu_y_load,
    output logic     alu_force_add,
    output logic     rotate_en,
    output logic     pc_inc,
    output logic     pc_load,
    output logic     mem_rd,
    output logic     mem_wr,
    output logic     complete,
    output logic     error
);

    state_e   state;
    state_e   next_state;
    opcode_e  opcode;
    reg_idx_t r1;               // destination, or the store / compare source
    reg_idx_t r2;               // operand a and base register
    reg_idx_t r3;
    fn_t      fn;
    logic     equal;
    logic     taken;

    assign opcode = opcode_e'(instr[31:26]);
    assign r1     = instr[25:21];
    assign r2     = instr[20:16];
    assign r3     = instr[15:11];
    assign fn     = instr[5:0];

    assign equal = alu_zero & ~alu_ovf;
    assign taken = (opcode == op_beq) ? equal : ~equal;

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            state <= fetch_addr;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            fetch_addr: next_state = fetch_wait;
            fetch_wait: next_state = mem_ready ? decode : fetch_wait;
            decode: begin
                case (opcode)
                    op_and, op_or, op_nor, op_xor, op_add, op_sub:
                        next_state = (fn == `CPU_FN_IMM_SHIFT) ? alu_op : fault;
                    op_andi, op_ori, op_xori, op_addi: next_state = imm_op;
                    op_beq, op_bne:                    next_state = br_cmp;
                    op_lw, op_sw:                      next_state = mem_addr;
                    op_nop:                            next_state = fetch_addr;
                    op_halt:                           next_state = done;
                    default:                           next_state = fault;
                endcase
            end
            alu_op:     next_state = alu_wb;
            imm_op:     next_state = imm_wb;
            alu_wb, imm_wb, load_wb:
                next_state = (r1 == '0) ? fault : fetch_addr;   // r0 is read only
            br_cmp:     next_state = br_test;
            br_test:    next_state = taken ? br_add : fetch_addr;
            br_add:     next_state = br_load;
            br_load:    next_state = fetch_addr;
            mem_addr:   next_state = mem_mar;
            mem_mar:    next_state = (opcode == op_lw) ? load_wait : store_wait;
            load_wait:  next_state = mem_ready ? load_wb : load_wait;
            store_wait: next_state = mem_ready ? fetch_addr : store_wait;
            done:       next_state = done;
            default:    next_state = fault;
        endcase
    end

    always_comb begin
        bus_src       = bus_pc;
        rd_idx        = r2;
        reg_wr        = 1'b0;
        ir_load       = 1'b0;
        mar_load      = 1'b0;
        mdr_load      = 1'b0;
        alu_a_load    = 1'b0;
        alu_y_load    = 1'b0;
        alu_force_add = 1'b0;
        rotate_en     = 1'b0;
        pc_inc        = 1'b0;
        pc_load       = 1'b0;
        mem_rd        = 1'b0;
        mem_wr        = 1'b0;
        case (state)
            fetch_addr: mar_load = 1'b1;                // bus carries the pc
            fetch_wait: begin
                mem_rd  = 1'b1;
                ir_load = mem_ready;                    // instruction valid with the strobe
                pc_inc  = mem_ready;
            end
            decode: begin
                bus_src    = bus_reg;                   // operand a = r2
                alu_a_load = 1'b1;
            end
            alu_op: begin
                bus_src    = bus_reg;
                rd_idx     = r3;
                alu_y_load = 1'b1;
                rotate_en  = 1'b1;
            end
            imm_op: begin
                bus_src    = bus_imm;
                alu_y_load = 1'b1;
            end
            alu_wb, imm_wb: begin
                bus_src = bus_alu;
                rd_idx  = r1;
                reg_wr  = (r1 != '0);
            end
            br_cmp: begin
                bus_src    = bus_reg;                   // r2 - r1 sets the flags
                rd_idx     = r1;
                alu_y_load = 1'b1;
            end
            br_test: alu_a_load = 1'b1;                 // incremented pc as base
            br_add, mem_addr: begin
                bus_src       = bus_imm;
                alu_y_load    = 1'b1;
                alu_force_add = 1'b1;
            end
            br_load: begin
                bus_src = bus_alu;
                pc_load = 1'b1;
            end
            mem_mar: begin
                bus_src  = bus_alu;
                rd_idx   = r1;
                mar_load = 1'b1;
            end
            load_wait: begin
                mem_rd   = 1'b1;
                mdr_load = mem_ready;
            end
            load_wb: begin
                bus_src = bus_membuf;
                rd_idx  = r1;
                reg_wr  = (r1 != '0);
            end
            store_wait: begin
                rd_idx = r1;                            // store data straight from the read port
                mem_wr = 1'b1;
            end
            default: ;
        endcase
    end

    assign complete = (state == done);
    assign error    = (state == fault);

endmodule

//--- datapath/alu.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module alu import cpu_pkg::*; (
    input  logic    clk,
    input  logic    reset_b,
    input  logic    a_load,     // operand a from the bus
    input  logic    y_load,     // a op bus into the result register
    input  logic    force_add,  // address and branch target sums
    input  logic    rotate_en,
    input  alu_op_t op,
    input  shamt_t  shamt,
    input  word_t   bus,
    output word_t   result,
    output logic    zero,
    output logic    ovf
);

    localparam int msb = `CPU_WORD_W - 1;

    word_t                     a_q;
    word_t                     y_q;
    word_t                     sum;
    word_t                     diff;
    word_t                     raw;
    word_t                     rot;
    logic                      raw_ovf;
    logic [2*`CPU_WORD_W-1:0]  dbl;

    assign sum  = a_q + bus;
    assign diff = a_q - bus;

    always_comb begin
        raw     = '0;
        raw_ovf = 1'b0;
        if (force_add || op == alu_op_t'(op_add)) begin
            raw     = sum;
            raw_ovf = (a_q[msb] == bus[msb]) && (sum[msb] != a_q[msb]);
        end else begin
            case (op)
                alu_op_t'(op_and): raw = a_q & bus;
                alu_op_t'(op_or):  raw = a_q | bus;
                alu_op_t'(op_nor): raw = ~(a_q | bus);
                alu_op_t'(op_xor): raw = a_q ^ bus;
                alu_op_t'(op_sub): begin
                    raw     = diff;
                    raw_ovf = (a_q[msb] != bus[msb]) && (diff[msb] != a_q[msb]);
                end
                default:           raw = '0;
            endcase
        end
    end

    // left rotate by shifting a doubled copy
    assign dbl = {raw, raw} << shamt;
    assign rot = rotate_en ? dbl[2*`CPU_WORD_W-1:`CPU_WORD_W] : raw;

    always_ff @(posedge clk) begin
        if (a_load) begin
            a_q <= bus;
        end
        if (y_load) begin
            y_q <= rot;
        end
    end

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            zero <= 1'b0;
            ovf  <= 1'b0;
        end else if (y_load) begin
            zero <= (rot == '0);
            ovf  <= raw_ovf;
        end
    end

    assign result = y_q;

endmodule

//--- datapath/datapath.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module datapath import cpu_pkg::*; (
    input  logic     clk,
    input  logic     reset_b,
    input  logic     ir_load,
    input  logic     mar_load,
    input  logic     mdr_load,
    input  logic     alu_a_load,
    input  logic     alu_y_load,
    input  logic     alu_force_add,
    input  logic     rotate_en,
    input  bus_src_e bus_src,
    input  reg_idx_t rd_idx,
    input  logic     reg_wr,
    input  word_t    pc,
    input  word_t    mem_rdata,
    output word_t    instr,
    output word_t    mem_addr,
    output word_t    mem_wdata,
    output word_t    bus,
    output logic     alu_zero,
    output logic     alu_ovf
);

    word_t  ir_q;
    word_t  mar_q;
    word_t  mdr_q;              // memory buffer for lw
    word_t  ext_imm;
    word_t  alu_result;
    word_t  reg_rdata;
    imm_t   imm;
    shamt_t shamt;

    assign imm     = ir_q[`CPU_IMM_W-1:0];
    assign shamt   = ir_q[10:6];
    assign ext_imm = {{(`CPU_WORD_W-`CPU_IMM_W){imm[`CPU_IMM_W-1]}}, imm};

    always_comb begin
        case (bus_src)
            bus_pc:     bus = pc;
            bus_reg:    bus = reg_rdata;
            bus_imm:    bus = ext_imm;
            bus_alu:    bus = alu_result;
            bus_membuf: bus = mdr_q;
            default:    bus = '0;
        endcase
    end

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            ir_q  <= '0;
            mar_q <= '0;
        end else begin
            if (ir_load) begin
                ir_q <= mem_rdata;
            end
            if (mar_load) begin
                mar_q <= bus;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mdr_load) begin
            mdr_q <= mem_rdata;
        end
    end

    assign instr     = ir_q;
    assign mem_addr  = mar_q;
    assign mem_wdata = reg_rdata;

    alu alu_i (
        .clk       (clk),
        .reset_b   (reset_b),
        .a_load    (alu_a_load),
        .y_load    (alu_y_load),
        .force_add (alu_force_add),
        .rotate_en (rotate_en),
        .op        (alu_op_t'(ir_q[29:26])),   // low opcode bits
        .shamt     (shamt),
        .bus       (bus),
        .result    (alu_result),
        .zero      (alu_zero),
        .ovf       (alu_ovf)
    );

    register_file regs_i (
        .clk     (clk),
        .reset_b (reset_b),
        .wr      (reg_wr),
        .idx     (rd_idx),
        .wdata   (bus),
        .rdata   (reg_rdata)
    );

endmodule

//--- datapath/register_file.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module register_file import cpu_pkg::*; (
    input  logic     clk,
    input  logic     reset_b,
    input  logic     wr,
    input  reg_idx_t idx,       // shared by the read and the write port
    input  word_t    wdata,
    output word_t    rdata
);

    word_t regs [`CPU_REG_CNT];

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            for (int i = 0; i < `CPU_REG_CNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr && idx != '0) begin
            regs[idx] <= wdata;
        end
    end

    // r0 is hardwired to zero
    assign rdata = (idx == '0) ? '0 : regs[idx];

endmodule

//--- files.f
+incdir+common
common/cpu_pkg.sv
src/program_counter.sv
control/cpu_control.sv
datapath/alu.sv
datapath/register_file.sv
datapath/datapath.sv
src/cpu.sv
testbench/tb_cpu.sv

//--- src/cpu.sv
`timescale 1ns/1ps

module cpu import cpu_pkg::*; (
    input  logic  clk,
    input  logic  reset_b,
    output word_t mem_addr,
    output word_t mem_wdata,
    output logic  mem_rd,
    output logic  mem_wr,
    input  word_t mem_rdata,
    input  logic  mem_ready,    // one cycle answer to mem_rd or mem_wr
    output logic  complete,
    output logic  error
);

    word_t    instr;
    word_t    pc;
    word_t    bus;              // internal bus, also feeds the pc load
    bus_src_e bus_src;
    reg_idx_t rd_idx;
    logic     reg_wr;
    logic     ir_load;
    logic     mar_load;
    logic     mdr_load;
    logic     alu_a_load;
    logic     alu_y_load;
    logic     alu_force_add;
    logic     rotate_en;
    logic     pc_inc;
    logic     pc_load;
    logic     alu_zero;
    logic     alu_ovf;

    cpu_control control_i (
        .clk           (clk),
        .reset_b       (reset_b),
        .instr         (instr),
        .mem_ready     (mem_ready),
        .alu_zero      (alu_zero),
        .alu_ovf       (alu_ovf),
        .bus_src       (bus_src),
        .rd_idx        (rd_idx),
        .reg_wr        (reg_wr),
        .ir_load       (ir_load),
        .mar_load      (mar_load),
        .mdr_load      (mdr_load),
        .alu_a_load    (alu_a_load),
        .alu_y_load    (alu_y_load),
        .alu_force_add (alu_force_add),
        .rotate_en     (rotate_en),
        .pc_inc        (pc_inc),
        .pc_load       (pc_load),
        .mem_rd        (mem_rd),
        .mem_wr        (mem_wr),
        .complete      (complete),
        .error         (error)
    );

    program_counter pc_i (
        .clk     (clk),
        .reset_b (reset_b),
        .inc     (pc_inc),
        .load    (pc_load),
        .bus     (bus),
        .pc      (pc)
    );

    datapath datapath_i (
        .clk           (clk),
        .reset_b       (reset_b),
        .ir_load       (ir_load),
        .mar_load      (mar_load),
        .mdr_load      (mdr_load),
        .alu_a_load    (alu_a_load),
        .alu_y_load    (alu_y_load),
        .alu_force_add (alu_force_add),
        .rotate_en     (rotate_en),
        .bus_src       (bus_src),
        .rd_idx        (rd_idx),
        .reg_wr        (reg_wr),
        .pc            (pc),
        .mem_rdata     (mem_rdata),
        .instr         (instr),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .bus           (bus),
        .alu_zero      (alu_zero),
        .alu_ovf       (alu_ovf)
    );

endmodule

//--- src/program_counter.sv
`timescale 1ns/1ps

module program_counter import cpu_pkg::*; (
    input  logic  clk,
    input  logic  reset_b,
    input  logic  inc,          // word addressed, so +1 per instruction
    input  logic  load,         // branch target from the bus
    input  word_t bus,
    output word_t pc
);

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            pc <= '0;
        end else if (load) begin
            pc <= bus;
        end else if (inc) begin
            pc <= pc + word_t'(1);
        end
    end

endmodule

//--- testbench/cpu_cases.txt
// cases for tb_cpu, all values hex, one 32-bit word per token
// per case: n, n program words | m, m data (address value) pairs |
//           s, s expected store (address value) pairs in order | outcome 1 complete, 2 error
// a program word count of zero ends the list

// register operations and, or, nor, xor, add, sub with rotates 4, 0, 8, 31, 1, 16
0F
A0400040 A0600041
00821900 04A21800 08C21A00 0CE21FC0 11021840 15221C00
A4800050 A4A00051 A4C00052 A4E00053 A5000054 A5200055
5C000000
02 40 F0F01234 41 0FF08765
06 50 0F002240 51 FFF09775 52 0F688A00 53 FF804AA8 54 01C13332 55 8ACFE0FF
01

// immediate operations with sign extension, lw and sw with a negative offset
0D
A0200040 9041FFFE 80618F0F 848100F0 8CA1FFFF 90C00044 A0E6FFFF
A4400050 A4600051 A4800052 A4A00053 A4E60010 5C000000
02 40 12345678 43 CAFEF00D
05 50 12345676 51 12340608 52 123456F8 53 EDCBA987 54 CAFEF00D
01

// beq and bne taken and not taken, then a backward countdown loop
11
90200005 90400005 90600007 54220002 A4200060 A4200061 D4230001 A4400062
54230001 A4600063 D4220001 A4200064 90800003 9084FFFF A4800070 D480FFFD
5C000000
00
05 63 00000007 64 00000005 70 00000002 70 00000001 70 00000000
01

// nop, then halt with a store behind it
05
4C000000 90200011 A4200050 5C000000 A4200051
00
01 50 00000011
01

// unknown opcode
05
90200022 A4200050 FC000000 A4200051 5C000000
00
01 50 00000022
02

// add with a nonzero function field
05
90200033 A4200050 10410801 A4400051 5C000000
00
01 50 00000033
02

// addi into register 0
05
90200044 A4200050 90010001 A4200051 5C000000
00
01 50 00000044
02

// lw into register 0
01
A0000040
01 40 00000055
00
02

00

//--- testbench/tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu import cpu_pkg::*; ();

    localparam int clk_half     = 50;
    localparam int mem_words    = 256;
    localparam int case_words   = 1024;
    localparam int reset_cycles = 10;
    localparam int run_timeout  = 5000;     // cycles per case
    localparam int quiet_cycles = 20;       // watched after complete or error

    logic  clk;
    logic  reset_b;
    word_t mem_addr;
    word_t mem_wdata;
    logic  mem_rd;
    logic  mem_wr;
    word_t mem_rdata;
    logic  mem_ready;
    logic  complete;
    logic  error;

    word_t mem [mem_words];                 // unified program and data memory
    word_t stream [case_words];             // raw words of the cases file
    word_t exp_store_addr [$];
    word_t exp_store_data [$];

    logic  req_pending;
    logic  req_is_wr;
    int    req_delay;
    word_t req_addr;
    word_t req_wdata;

    cpu dut_i (
        .clk       (clk),
        .reset_b   (reset_b),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rd    (mem_rd),
        .mem_wr    (mem_wr),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready),
        .complete  (complete),
        .error     (error)
    );

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            stop_run($sformatf("ERR time=%0t signal=%s expected=%h actual=%h",
                               $time, name, expected, actual));
        end
    endtask

    task automatic take_word(inout int ptr, output word_t value);
        if (ptr >= case_words) begin
            stop_run("the cases file ends in the middle of a case");
        end else begin
            value = stream[ptr];
            ptr++;
        end
    endtask

    // reads return data and writes are matched against the expected stores
    task automatic answer_request();
        int idx;
        idx = int'(req_addr);
        if (req_addr >= mem_words) begin
            stop_run($sformatf("memory access outside the model at address %h", req_addr));
        end else if (req_is_wr && exp_store_addr.size() == 0) begin
            stop_run($sformatf("store to %h was not expected", req_addr));
        end else if (req_is_wr) begin
            check_value("store address", exp_store_addr.pop_front(), req_addr);
            check_value("store data", exp_store_data.pop_front(), req_wdata);
            mem[idx]  = req_wdata;
            mem_ready = 1'b1;
        end else begin
            mem_rdata = mem[idx];
            mem_ready = 1'b1;
        end
    endtask

    task automatic load_case(inout int ptr, output logic want_error);
        word_t count;
        word_t addr;
        word_t value;
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = 32'hF00D_0000 ^ word_t'(i);    // unknown opcode if fetched
        end
        exp_store_addr.delete();
        exp_store_data.delete();
        take_word(ptr, count);
        for (int i = 0; i < count; i++) begin
            take_word(ptr, value);
            mem[i] = value;
        end
        take_word(ptr, count);
        for (int i = 0; i < count; i++) begin
            take_word(ptr, addr);
            take_word(ptr, value);
            mem[addr[7:0]] = value;
        end
        take_word(ptr, count);
        for (int i = 0; i < count; i++) begin
            take_word(ptr, addr);
            take_word(ptr, value);
            exp_store_addr.push_back(addr);
            exp_store_data.push_back(value);
        end
        take_word(ptr, value);
        if (value != 1 && value != 2) begin
            stop_run($sformatf("unknown outcome code %h in the cases file", value));
        end else begin
            want_error = (value == 2);
        end
    endtask

    task automatic run_case(inout int ptr, input int case_no);
        logic want_error;
        int   cycles;
        @(posedge clk);
        #1;
        reset_b = 1'b0;
        load_case(ptr, want_error);
        repeat (reset_cycles) @(posedge clk);
        #1;
        check_value("complete", 0, complete);
        check_value("error", 0, error);
        check_value("mem_rd", 0, mem_rd);
        check_value("mem_wr", 0, mem_wr);
        reset_b = 1'b1;
        cycles  = 0;
        while (!(complete || error)) begin
            if (cycles >= run_timeout) begin
                stop_run($sformatf("case %0d timed out waiting for complete or error", case_no));
            end else begin
                @(posedge clk);
                #1;
                cycles++;
            end
        end
        check_value("complete", word_t'(!want_error), complete);
        check_value("error", word_t'(want_error), error);
        repeat (quiet_cycles) begin            // outcome holds and no further requests follow
            @(posedge clk);
            #1;
            check_value("mem_rd", 0, mem_rd);
            check_value("mem_wr", 0, mem_wr);
            check_value("complete", word_t'(!want_error), complete);
            check_value("error", word_t'(want_error), error);
        end
        check_value("stores missing", 0, exp_store_addr.size());
        $display("case %0d finished after %0d cycles", case_no, cycles);
    endtask

    initial begin
        clk = 1'b0;
        forever #clk_half clk = ~clk;
    end

    // memory model answering each request after 1 to 4 cycles
    initial begin : memory_model
        void'($urandom(21943));
        req_pending = 1'b0;
        req_is_wr   = 1'b0;
        req_delay   = 0;
        forever begin
            @(posedge clk);
            #1;
            mem_ready = 1'b0;
            if (!reset_b) begin
                req_pending = 1'b0;
            end else if (mem_rd && mem_wr) begin
                stop_run("mem_rd and mem_wr are high in the same cycle");
            end else begin
                if (req_pending && !(req_is_wr ? mem_wr : mem_rd)) begin
                    stop_run("memory request dropped before mem_ready");
                end else if (req_pending) begin
                    check_value("mem_addr", req_addr, mem_addr);
                    if (req_is_wr) begin
                        check_value("mem_wdata", req_wdata, mem_wdata);
                    end
                end else if (mem_rd || mem_wr) begin
                    req_pending = 1'b1;
                    req_is_wr   = mem_wr;
                    req_addr    = mem_addr;
                    req_wdata   = mem_wdata;
                    req_delay   = $urandom % 4;
                end
                if (req_pending && req_delay == 0) begin
                    answer_request();
                    req_pending = 1'b0;
                end else if (req_pending) begin
                    req_delay--;
                end
            end
        end
    end

    initial begin : run_all
        int ptr;
        int case_no;
        reset_b   = 1'b1;
        mem_rdata = '0;
        mem_ready = 1'b0;
        for (int i = 0; i < case_words; i++) begin
            stream[i] = '0;
        end
        $readmemh("testbench/cpu_cases.txt", stream);
        ptr     = 0;
        case_no = 0;
        while (ptr < case_words && stream[ptr] != '0) begin   // zero count ends the list
            run_case(ptr, case_no);
            case_no++;
        end
        if (case_no == 0) begin
            stop_run("no cases found in testbench/cpu_cases.txt");
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule
